// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_epb_opb_bridge -f tb.f \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_epb_opb_bridge > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0

// ==== source/epb_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module epb_capture (
  input  logic               OPB_Clk,
  input  logic               arst_n,
  input  logic               epb_cs_n,
  input  logic               epb_oe_n,
  input  logic               epb_r_w_n,
  input  epb_pkg::epb_be_t   epb_be_n,
  input  epb_pkg::epb_addr_t epb_addr,
  input  epb_pkg::epb_gp_t   epb_addr_gp,
  input  epb_pkg::epb_data_t epb_data_i,
  output logic               cs_n_q,
  output logic               oe_n_q,
  output logic               r_w_n_q,
  output epb_pkg::epb_be_t   be_n_q,
  output epb_pkg::epb_addr_t addr_q,
  output epb_pkg::epb_gp_t   gp_q,
  output epb_pkg::epb_data_t data_q,
  output logic               trans_strb,
  output logic               epb_data_oe_n
);

  logic prev_cs_n;

  // strobes come up inactive after reset
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      cs_n_q    <= 1'b1;
      prev_cs_n <= 1'b1;
      oe_n_q    <= 1'b1;
      r_w_n_q   <= 1'b1;
    end else begin
      cs_n_q    <= epb_cs_n;
      prev_cs_n <= cs_n_q;
      oe_n_q    <= epb_oe_n;
      r_w_n_q   <= epb_r_w_n;
    end
  end

  // address and data pins, one register stage at the pads
  always_ff @(posedge OPB_Clk) begin
    be_n_q <= epb_be_n;
    addr_q <= epb_addr;
    gp_q   <= epb_addr_gp;
    data_q <= epb_data_i;
  end

  // one cycle pulse on the falling edge of the captured chip select
  assign trans_strb = prev_cs_n & ~cs_n_q;

  // drive the data pins only for a selected read with output enable low
  assign epb_data_oe_n = ~r_w_n_q | cs_n_q | oe_n_q;

endmodule

`default_nettype wire

// ==== source/epb_opb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module epb_opb_bridge (
  input  logic               epb_cs_n,
  input  logic               epb_oe_n,
  input  logic               epb_r_w_n,
  input  epb_pkg::epb_be_t   epb_be_n,
  input  epb_pkg::epb_addr_t epb_addr,
  input  epb_pkg::epb_gp_t   epb_addr_gp,
  input  epb_pkg::epb_data_t epb_data_i,
  output epb_pkg::epb_data_t epb_data_o,
  output logic               epb_data_oe_n,
  output logic               epb_rdy,
  output logic               epb_rdy_oe,

  input  logic               OPB_Clk,
  input  logic               arst_n,
  input  logic               opb_rst,
  output logic               m_request,
  output logic               m_bus_lock,
  output logic               m_select,
  output logic               m_rnw,
  output logic               m_seq_addr,
  output opb_pkg::opb_be_t   m_be,
  output opb_pkg::opb_data_t m_dbus,
  output opb_pkg::opb_addr_t m_abus,
  // grant is ignored, the bridge holds the bus locked
  input  logic               opb_mgrant,
  input  logic               opb_xfer_ack,
  input  logic               opb_err_ack,
  input  logic               opb_retry,
  input  logic               opb_timeout,
  input  opb_pkg::opb_data_t opb_dbus
);

  import epb_pkg::*;
  import opb_pkg::*;

  logic        r_w_n_q;
  epb_be_t     be_n_q;
  epb_addr_t   addr_q;
  epb_gp_t     gp_q;
  epb_data_t   data_q;
  logic        trans_strb;
  xfer_state_e state;
  logic        timed_out;

  // single master, no bursts
  assign m_request  = 1'b1;
  assign m_bus_lock = 1'b1;
  assign m_seq_addr = 1'b0;

  assign epb_rdy_oe = ~epb_cs_n;

  // captured chip select and output enable only feed the data output enable
  epb_capture u_epb_capture (
    .OPB_Clk       (OPB_Clk),
    .arst_n        (arst_n),
    .epb_cs_n      (epb_cs_n),
    .epb_oe_n      (epb_oe_n),
    .epb_r_w_n     (epb_r_w_n),
    .epb_be_n      (epb_be_n),
    .epb_addr      (epb_addr),
    .epb_addr_gp   (epb_addr_gp),
    .epb_data_i    (epb_data_i),
    .cs_n_q        (),
    .oe_n_q        (),
    .r_w_n_q       (r_w_n_q),
    .be_n_q        (be_n_q),
    .addr_q        (addr_q),
    .gp_q          (gp_q),
    .data_q        (data_q),
    .trans_strb    (trans_strb),
    .epb_data_oe_n (epb_data_oe_n)
  );

  opb_request_mapper u_opb_request_mapper (
    .m_select (m_select),
    .r_w_n_q  (r_w_n_q),
    .addr_q   (addr_q),
    .gp_q     (gp_q),
    .be_n_q   (be_n_q),
    .data_q   (data_q),
    .m_rnw    (m_rnw),
    .m_abus   (m_abus),
    .m_be     (m_be),
    .m_dbus   (m_dbus)
  );

  opb_xfer_ctrl u_opb_xfer_ctrl (
    .OPB_Clk      (OPB_Clk),
    .arst_n       (arst_n),
    .opb_rst      (opb_rst),
    .trans_strb   (trans_strb),
    .opb_xfer_ack (opb_xfer_ack),
    .opb_err_ack  (opb_err_ack),
    .opb_retry    (opb_retry),
    .opb_timeout  (opb_timeout),
    .m_select     (m_select),
    .state        (state),
    .timed_out    (timed_out)
  );

  epb_reply_stage u_epb_reply_stage (
    .OPB_Clk      (OPB_Clk),
    .arst_n       (arst_n),
    .epb_cs_n     (epb_cs_n),
    .lane_lo      (addr_q[0]),
    .timed_out    (timed_out),
    .opb_xfer_ack (opb_xfer_ack),
    .opb_err_ack  (opb_err_ack),
    .opb_retry    (opb_retry),
    .opb_timeout  (opb_timeout),
    .state        (state),
    .opb_dbus     (opb_dbus),
    .epb_data_o   (epb_data_o),
    .epb_rdy      (epb_rdy)
  );

endmodule

`default_nettype wire

// ==== source/epb_pkg.sv ====
`default_nettype none

package epb_pkg;

  // widths of the external processor bus
  localparam int epb_addr_bits = 23;
  localparam int epb_gp_bits   = 6;
  localparam int epb_data_bits = 16;
  localparam int epb_be_bits   = 2;

  // half-word address, bit 0 set selects the low OPB half
  typedef logic [epb_addr_bits-1:0] epb_addr_t;

  // general-purpose address bits, only the low three reach the OPB
  typedef logic [epb_gp_bits-1:0] epb_gp_t;

  typedef logic [epb_data_bits-1:0] epb_data_t;

  // active low, one per byte of the half-word
  typedef logic [epb_be_bits-1:0] epb_be_t;

  // read back when no reply was captured
  localparam epb_data_t epb_idle_data = 16'hc0de;

  // read back after the transfer timed out
  localparam epb_data_t epb_fault_data = 16'hdead;

endpackage

`default_nettype wire

// ==== source/epb_reply_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module epb_reply_stage (
  input  logic                 OPB_Clk,
  input  logic                 arst_n,
  input  logic                 epb_cs_n,
  input  logic                 lane_lo,
  input  logic                 timed_out,
  input  logic                 opb_xfer_ack,
  input  logic                 opb_err_ack,
  input  logic                 opb_retry,
  input  logic                 opb_timeout,
  input  opb_pkg::xfer_state_e state,
  input  opb_pkg::opb_data_t   opb_dbus,
  output epb_pkg::epb_data_t   epb_data_o,
  output logic                 epb_rdy
);

  import epb_pkg::*;
  import opb_pkg::*;

  logic      reply_seen;
  epb_data_t reply_half;
  epb_data_t data_q;
  logic      rdy_q;

  // a reply only counts while the controller is waiting for one
  assign reply_seen = (state == xfer_wait) &&
                      (opb_xfer_ack | opb_err_ack | opb_retry | opb_timeout);

  assign reply_half = lane_lo ? opb_dbus[opb_half_bits-1:0] :
                                opb_dbus[opb_data_bits-1:opb_half_bits];

  // idle pattern unless this cycle ended a transfer
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      data_q <= epb_idle_data;
    end else begin
      data_q <= epb_idle_data;
      if (timed_out) begin
        data_q <= epb_fault_data;
      end
      if (reply_seen) begin
        data_q <= reply_half;
      end
    end
  end

  // ready stays set until the processor drops chip select
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy_q <= 1'b0;
    end else if (epb_cs_n) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= rdy_q | reply_seen | timed_out;
    end
  end

  // pins change half a cycle later, away from the processor sample point
  always_ff @(negedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      epb_data_o <= epb_idle_data;
      epb_rdy    <= 1'b0;
    end else begin
      epb_data_o <= data_q;
      epb_rdy    <= rdy_q;
    end
  end

endmodule

`default_nettype wire

// ==== source/opb_pkg.sv ====
`default_nettype none

package opb_pkg;

  // OPB bit 0 is the msb, so bit 31 of a descending bus is OPB bit 0
  localparam int opb_addr_bits = 32;
  localparam int opb_data_bits = 32;
  localparam int opb_be_bits   = 4;

  typedef logic [opb_addr_bits-1:0] opb_addr_t;

  typedef logic [opb_data_bits-1:0] opb_data_t;

  typedef logic [opb_be_bits-1:0] opb_be_t;

  // one EPB half-word occupies half of an OPB word
  localparam int opb_half_bits = opb_data_bits / 2;

  // transfer controller states
  typedef enum logic {
    xfer_idle = 1'b0,
    xfer_wait = 1'b1
  } xfer_state_e;

  // width of the reply timeout counter
  // the top bit sets after 512 cycles in wait
  localparam int opb_timeout_bits = 10;

  // byte lanes asserted for a half-word read
  localparam opb_be_t opb_be_hi_half = 4'b1100;
  localparam opb_be_t opb_be_lo_half = 4'b0011;

endpackage

`default_nettype wire

// ==== source/opb_request_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module opb_request_mapper (
  input  logic               m_select,
  input  logic               r_w_n_q,
  input  epb_pkg::epb_addr_t addr_q,
  input  epb_pkg::epb_gp_t   gp_q,
  input  epb_pkg::epb_be_t   be_n_q,
  input  epb_pkg::epb_data_t data_q,
  output logic               m_rnw,
  output opb_pkg::opb_addr_t m_abus,
  output opb_pkg::opb_be_t   m_be,
  output opb_pkg::opb_data_t m_dbus
);

  import opb_pkg::*;

  opb_addr_t word_addr;
  opb_be_t   lane_be;
  opb_data_t lane_data;
  logic      lane_lo;

  // word-aligned byte address, top five bits unused
  assign word_addr = {5'b0, gp_q[2:0], addr_q[22:1], 2'b00};

  // odd half-word addresses live in OPB bits 16 to 31
  assign lane_lo = addr_q[0];

  always_comb begin
    if (r_w_n_q) begin
      // reads fetch the whole half-word
      lane_be   = lane_lo ? opb_be_lo_half : opb_be_hi_half;
      lane_data = '0;
    end else if (lane_lo) begin
      lane_be   = {2'b00, ~be_n_q};
      lane_data = {{opb_half_bits{1'b0}}, data_q};
    end else begin
      lane_be   = {~be_n_q, 2'b00};
      lane_data = {data_q, {opb_half_bits{1'b0}}};
    end
  end

  // the OPB requires zeros from a master that is not selected
  always_comb begin
    if (m_select) begin
      m_rnw  = r_w_n_q;
      m_abus = word_addr;
      m_be   = lane_be;
      m_dbus = lane_data;
    end else begin
      m_rnw  = 1'b0;
      m_abus = '0;
      m_be   = '0;
      m_dbus = '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/opb_xfer_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module opb_xfer_ctrl (
  input  logic                 OPB_Clk,
  input  logic                 arst_n,
  input  logic                 opb_rst,
  input  logic                 trans_strb,
  input  logic                 opb_xfer_ack,
  input  logic                 opb_err_ack,
  input  logic                 opb_retry,
  input  logic                 opb_timeout,
  output logic                 m_select,
  output opb_pkg::xfer_state_e state,
  output logic                 timed_out
);

  import opb_pkg::*;

  logic                        select_q;
  logic                        reply;
  logic [opb_timeout_bits-1:0] timeout_cnt;

  // any of these ends the current transfer
  assign reply = opb_xfer_ack | opb_err_ack | opb_retry | opb_timeout;

  assign timed_out = (state == xfer_wait) && timeout_cnt[opb_timeout_bits-1];

  // select goes out in the strobe cycle itself, the register holds it after
  assign m_select = select_q | ((state == xfer_idle) && trans_strb);

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= xfer_idle;
      select_q <= 1'b0;
    end else if (opb_rst) begin
      state    <= xfer_idle;
      select_q <= 1'b0;
    end else begin
      case (state)
        xfer_idle: begin
          if (trans_strb) begin
            state    <= xfer_wait;
            select_q <= 1'b1;
          end
        end
        xfer_wait: begin
          if (reply || timed_out) begin
            state    <= xfer_idle;
            select_q <= 1'b0;
          end
        end
        default: begin
          state    <= xfer_idle;
          select_q <= 1'b0;
        end
      endcase
    end
  end

  // counts cycles spent waiting for the slave
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      timeout_cnt <= '0;
    end else if ((state == xfer_idle) && trans_strb) begin
      timeout_cnt <= '0;
    end else if (state == xfer_wait) begin
      timeout_cnt <= timeout_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
source/epb_pkg.sv
source/opb_pkg.sv
source/epb_capture.sv
source/opb_request_mapper.sv
source/opb_xfer_ctrl.sv
source/epb_reply_stage.sv
source/epb_opb_bridge.sv
tb/epb_opb_bridge_asserts.sv
tb/tb_epb_opb_bridge.sv

// ==== tb/epb_opb_bridge_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module epb_opb_bridge_asserts (
  input logic OPB_Clk,
  input logic arst_n,
  input logic epb_cs_n,
  input logic epb_r_w_n,
  input logic m_select,
  input logic epb_rdy,
  input logic epb_data_oe_n
);

  // a transfer only starts under an active chip select
  select_needs_cs: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    $rose(m_select) |-> !epb_cs_n)
    else $error("m_select rose while epb_cs_n was high");

  // ready drops by the next cycle once the processor lets go
  rdy_follows_cs: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    $rose(epb_cs_n) |=> !epb_rdy)
    else $error("epb_rdy still high one cycle after epb_cs_n rose");

  // the captured r_w_n is the pin value one cycle back
  no_drive_on_write: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    !$past(epb_r_w_n) |-> epb_data_oe_n)
    else $error("epb_data_oe_n low during a write");

endmodule

bind epb_opb_bridge epb_opb_bridge_asserts u_epb_opb_bridge_asserts (
  .OPB_Clk       (OPB_Clk),
  .arst_n        (arst_n),
  .epb_cs_n      (epb_cs_n),
  .epb_r_w_n     (epb_r_w_n),
  .m_select      (m_select),
  .epb_rdy       (epb_rdy),
  .epb_data_oe_n (epb_data_oe_n)
);

`default_nettype wire

// ==== tb/tb_epb_opb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_epb_opb_bridge;

  import epb_pkg::*;
  import opb_pkg::*;

  localparam int access_count        = 20;
  localparam int access_cycles       = 40;
  localparam int timeout_test_cycles = 600;
  localparam int margin_cycles       = 200;
  localparam int watchdog_cycles     = 4 + access_count * access_cycles +
                                       timeout_test_cycles + margin_cycles;

  logic      OPB_Clk;
  logic      arst_n;
  logic      opb_rst;
  logic      epb_cs_n;
  logic      epb_oe_n;
  logic      epb_r_w_n;
  epb_be_t   epb_be_n;
  epb_addr_t epb_addr;
  epb_gp_t   epb_addr_gp;
  epb_data_t epb_data_i;
  epb_data_t epb_data_o;
  logic      epb_data_oe_n;
  logic      epb_rdy;
  logic      epb_rdy_oe;
  logic      m_request;
  logic      m_bus_lock;
  logic      m_select;
  logic      m_rnw;
  logic      m_seq_addr;
  opb_be_t   m_be;
  opb_data_t m_dbus;
  opb_addr_t m_abus;
  logic      opb_mgrant   = 1'b1;
  logic      opb_xfer_ack = 1'b0;
  logic      opb_err_ack  = 1'b0;
  logic      opb_retry    = 1'b0;
  logic      opb_timeout  = 1'b0;
  opb_data_t opb_dbus     = '0;

  // slave memory, its expected image and the access it last saw
  opb_data_t mem [0:15];
  opb_data_t exp_mem [0:15];
  opb_addr_t seen_abus;
  opb_be_t   seen_be;
  opb_data_t seen_dbus;
  logic      seen_rnw;
  logic      slave_busy = 1'b0;
  int        slave_wait = 0;
  // 0 xferAck, 1 errAck, 2 retry, 3 silent
  int        reply_mode = 0;
  int        seed       = 32'hc33e8540;
  int        cycle_cnt  = 0;
  int        sel_cycle  = 0;
  int        sel_count  = 0;
  int        err_cnt    = 0;
  int        check_cnt  = 0;
  int        test_cnt   = 0;

  epb_opb_bridge u_epb_opb_bridge (.*);

  initial begin
    OPB_Clk = 1'b0;
    forever #50 OPB_Clk = ~OPB_Clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge OPB_Clk);
    $display("watchdog expired before the tests completed");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic opb_data_t fill_word(input int idx);
    return (32'h9e3779b9 * (idx + 1)) ^ 32'h5a5a0000;
  endfunction

  // byte lane b is bits 8b+7 to 8b
  function automatic opb_data_t merge_word(input opb_data_t old, input opb_data_t wr,
                                           input opb_be_t be);
    opb_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wr[8*b +: 8];
    end
    return res;
  endfunction

  // OPB slave, replies after 1 to 4 cycles unless told to stay silent
  always @(posedge OPB_Clk) begin : slave_model
    #10;
    cycle_cnt = cycle_cnt + 1;
    opb_xfer_ack = 1'b0;
    opb_err_ack  = 1'b0;
    opb_retry    = 1'b0;
    opb_dbus     = '0;
    if (!arst_n) begin
      for (int k = 0; k < 16; k++) mem[k] = fill_word(k);
      slave_busy = 1'b0;
    end else if (slave_busy && !m_select) begin
      // master gave up
      slave_busy = 1'b0;
    end else if (slave_busy) begin
      slave_wait = slave_wait - 1;
      if (slave_wait == 0) begin
        slave_busy = 1'b0;
        if (reply_mode == 1) opb_err_ack = 1'b1;
        else if (reply_mode == 2) opb_retry = 1'b1;
        else opb_xfer_ack = 1'b1;
        if (seen_rnw) opb_dbus = mem[seen_abus[5:2]];
        else if (reply_mode == 0)
          mem[seen_abus[5:2]] = merge_word(mem[seen_abus[5:2]], seen_dbus, seen_be);
      end
    end else if (m_select) begin
      sel_count  = sel_count + 1;
      sel_cycle  = cycle_cnt;
      seen_abus  = m_abus;
      seen_be    = m_be;
      seen_dbus  = m_dbus;
      seen_rnw   = m_rnw;
      slave_busy = 1'b1;
      slave_wait = (reply_mode == 3) ? 100000 : 1 + ($random(seed) & 3);
    end
  end

  task automatic report_failure(input string what);
    $display("Failure: %s", what);
    err_cnt++;
  endtask

  task automatic check_data(input string name, input epb_data_t got, input epb_data_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input opb_addr_t got, input opb_addr_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_be(input string name, input opb_be_t got, input opb_be_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_word(input string name, input opb_data_t got, input opb_data_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) $display("test %s: passed", name);
    else $display("test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic wait_rdy(input int limit, output logic seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(posedge OPB_Clk);
      n++;
      if (epb_rdy) seen = 1'b1;
    end
  endtask

  // processor side of one access, chip select is left low
  task automatic epb_access(input logic rnw, input epb_addr_t addr, input epb_gp_t gp,
                            input epb_be_t be_n, input epb_data_t wdata, input int limit,
                            output logic got_rdy, output epb_data_t rdata,
                            output logic oe_seen);
    @(posedge OPB_Clk);
    #10;
    epb_addr    = addr;
    epb_addr_gp = gp;
    epb_be_n    = be_n;
    epb_data_i  = wdata;
    epb_r_w_n   = rnw;
    epb_oe_n    = ~rnw;
    epb_cs_n    = 1'b0;
    wait_rdy(limit, got_rdy);
    rdata   = epb_data_o;
    oe_seen = epb_data_oe_n;
    if (!got_rdy) report_failure($sformatf("no epb_rdy within %0d cycles", limit));
  endtask

  task automatic epb_release();
    @(posedge OPB_Clk);
    #10;
    epb_cs_n  = 1'b1;
    epb_oe_n  = 1'b1;
    epb_r_w_n = 1'b1;
    repeat (2) @(posedge OPB_Clk);
    check_bit("epb_rdy", epb_rdy, 1'b0);
    check_bit("epb_rdy_oe", epb_rdy_oe, 1'b0);
  endtask

  task automatic write_and_check(input epb_addr_t addr, input epb_gp_t gp,
                                 input epb_be_t be_n, input epb_data_t wdata);
    opb_addr_t exp_abus;
    opb_be_t   exp_be;
    opb_data_t exp_dbus;
    logic      got_rdy;
    epb_data_t rdata;
    logic      oe_seen;
    exp_abus = {5'b0, gp[2:0], addr[22:1], 2'b00};
    exp_be   = addr[0] ? {2'b00, ~be_n} : {~be_n, 2'b00};
    exp_dbus = addr[0] ? {16'h0000, wdata} : {wdata, 16'h0000};
    exp_mem[addr[4:1]] = merge_word(exp_mem[addr[4:1]], exp_dbus, exp_be);
    epb_access(1'b0, addr, gp, be_n, wdata, 20, got_rdy, rdata, oe_seen);
    check_addr("m_abus", seen_abus, exp_abus);
    check_be("m_be", seen_be, exp_be);
    check_word("m_dbus", seen_dbus, exp_dbus);
    check_bit("m_rnw", seen_rnw, 1'b0);
    check_bit("epb_data_oe_n", oe_seen, 1'b1);
    check_word("slave memory", mem[addr[4:1]], exp_mem[addr[4:1]]);
    epb_release();
  endtask

  task automatic read_and_check(input epb_addr_t addr, input epb_gp_t gp, input int mode);
    opb_data_t word;
    epb_data_t exp_half;
    logic      got_rdy;
    epb_data_t rdata;
    logic      oe_seen;
    reply_mode = mode;
    word       = exp_mem[addr[4:1]];
    exp_half   = addr[0] ? word[15:0] : word[31:16];
    epb_access(1'b1, addr, gp, 2'b00, 16'h0000, 20, got_rdy, rdata, oe_seen);
    check_bit("epb_rdy", got_rdy, 1'b1);
    check_data("epb_data_o", rdata, exp_half);
    check_bit("epb_data_oe_n", oe_seen, 1'b0);
    check_bit("m_rnw", seen_rnw, 1'b1);
    check_be("m_be", seen_be, addr[0] ? 4'b0011 : 4'b1100);
    epb_release();
    reply_mode = 0;
  endtask

  task automatic test_write_mapping();
    int errs_before;
    errs_before = err_cnt;
    write_and_check(23'h000004, 6'd1, 2'b00, 16'h1234);
    write_and_check(23'h000005, 6'd1, 2'b01, 16'habcd);
    write_and_check(23'h00000a, 6'd5, 2'b10, 16'h5678);
    write_and_check(23'h7ffffb, 6'd7, 2'b00, 16'h9abc);
    end_test("write mapping", errs_before);
  endtask

  task automatic test_read_lanes();
    int errs_before;
    errs_before = err_cnt;
    read_and_check(23'h000004, 6'd1, 0);
    read_and_check(23'h000005, 6'd1, 0);
    read_and_check(23'h00000a, 6'd5, 0);
    read_and_check(23'h00000f, 6'd3, 0);
    end_test("read lanes", errs_before);
  endtask

  task automatic test_reply_kinds();
    int errs_before;
    errs_before = err_cnt;
    read_and_check(23'h00000b, 6'd5, 1);
    read_and_check(23'h000004, 6'd2, 2);
    end_test("reply kinds", errs_before);
  endtask

  task automatic test_timeout();
    int        errs_before;
    logic      got_rdy;
    epb_data_t rdata;
    logic      oe_seen;
    int        waited;
    errs_before = err_cnt;
    reply_mode  = 3;
    epb_access(1'b1, 23'h000006, 6'd2, 2'b00, 16'h0000, 700, got_rdy, rdata, oe_seen);
    waited = cycle_cnt - sel_cycle;
    if (waited < 512) report_failure($sformatf("epb_rdy came %0d cycles after select", waited));
    check_data("epb_data_o", rdata, 16'hdead);
    check_bit("m_select", m_select, 1'b0);
    epb_release();
    reply_mode = 0;
    end_test("timeout", errs_before);
  endtask

  task automatic test_release_idle();
    int        errs_before;
    int        count_before;
    logic      got_rdy;
    epb_data_t rdata;
    logic      oe_seen;
    errs_before = err_cnt;
    epb_access(1'b1, 23'h00000a, 6'd5, 2'b00, 16'h0000, 20, got_rdy, rdata, oe_seen);
    check_bit("epb_rdy_oe", epb_rdy_oe, 1'b1);
    // second access under the same chip select
    count_before = sel_count;
    @(posedge OPB_Clk);
    #10;
    epb_r_w_n  = 1'b0;
    epb_oe_n   = 1'b1;
    epb_addr   = 23'h000004;
    epb_data_i = 16'hffff;
    repeat (20) @(posedge OPB_Clk);
    check_bit("m_select", m_select, 1'b0);
    check_bit("epb_rdy", epb_rdy, 1'b1);
    if (sel_count != count_before) report_failure("m_select rose without a new chip select");
    epb_release();
    repeat (2) @(posedge OPB_Clk);
    check_data("epb_data_o", epb_data_o, 16'hc0de);
    end_test("release and idle", errs_before);
  endtask

  initial begin
    epb_cs_n    = 1'b1;
    epb_oe_n    = 1'b1;
    epb_r_w_n   = 1'b1;
    epb_be_n    = 2'b11;
    epb_addr    = '0;
    epb_addr_gp = '0;
    epb_data_i  = '0;
    opb_rst     = 1'b0;
    arst_n      = 1'b0;
    for (int k = 0; k < 16; k++) exp_mem[k] = fill_word(k);
    repeat (4) @(posedge OPB_Clk);
    #10;
    arst_n = 1'b1;
    @(posedge OPB_Clk);
    check_data("epb_data_o", epb_data_o, 16'hc0de);
    check_bit("m_select", m_select, 1'b0);
    // single master without bursts
    check_bit("m_request", m_request, 1'b1);
    check_bit("m_bus_lock", m_bus_lock, 1'b1);
    check_bit("m_seq_addr", m_seq_addr, 1'b0);
    test_write_mapping();
    test_read_lanes();
    test_reply_kinds();
    test_timeout();
    test_release_idle();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
